// File: lsu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Load/store unit package
// Bus widths, access-size and request-phase encodings, the packed
// records passed between the LSU blocks and the shared split rule
////////////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // Data and address width of the core and the data bus
  parameter int unsigned DATA_W = 32;

  // One byte enable per data byte
  parameter int unsigned BE_W = DATA_W / 8;

  // Outstanding bus transactions allowed unless the top level overrides it
  parameter int unsigned DEPTH_DEFAULT = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Access size, same coding as the funct3 low bits of a load/store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Address phase of the operation currently held in EX
  typedef enum logic {
    PHASE_FIRST  = 1'b0,
    PHASE_SECOND = 1'b1
  } lsu_phase_e;

  ////////////////////////////////////////////////////////////////////////////
  // Records
  ////////////////////////////////////////////////////////////////////////////

  // Operation presented by the EX stage
  typedef struct packed {
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] wdata;
    lsu_size_e         size;
    logic              sext;
    logic              we;
  } lsu_req_t;

  // Address phase payload on the data bus
  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // Response phase payload on the data bus
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_resp_t;

  // What the WB side needs to process one response
  // last is low only for the first half of a split access
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    logic       last;
  } resp_ctrl_t;

  // Word at a nonzero offset or halfword at offset 3 crosses a word
  function automatic logic is_split(lsu_size_e size, logic [1:0] offset);
    return ((size == SIZE_WORD) && (offset != 2'b00)) ||
           ((size == SIZE_HALF) && (offset == 2'b11));
  endfunction

endpackage

// File: lsu_req_gen.sv
////////////////////////////////////////////////////////////////////////////
// LSU request generation
// Forms the data address in EX, builds byte enables and rotated write
// data, splits word-crossing accesses into two bus requests and drives
// the EX handshake and the response-control record for each grant
////////////////////////////////////////////////////////////////////////////

module lsu_req_gen (
  input  logic                clk,
  input  logic                rst_n,

  // EX stage
  input  logic                ex_valid_i,
  input  lsu_pkg::lsu_req_t   ex_req_i,
  output logic                ex_ready_o,

  // Pending queue state
  input  logic                full_i,

  // Data bus address phase
  output logic                obi_req_o,
  input  logic                obi_gnt_i,
  output lsu_pkg::obi_req_t   obi_o,

  // Record for the pending queue
  output logic                push_o,
  output lsu_pkg::resp_ctrl_t push_ctrl_o
);

  import lsu_pkg::*;

  logic [DATA_W-1:0]   addr;
  logic [DATA_W-1:0]   addr_next_word;
  logic [1:0]          offset;
  logic                split;
  logic                last;
  logic                grant;
  logic [BE_W-1:0]     be_base;
  logic [2*BE_W-1:0]   be_wide;
  logic [BE_W-1:0]     be;
  logic [2*DATA_W-1:0] wdata_dbl;
  logic [DATA_W-1:0]   wdata_rot;
  lsu_phase_e          phase_q;

  // Effective address, the low bits give the byte offset in the word
  assign addr   = ex_req_i.operand_a + ex_req_i.operand_b;
  assign offset = addr[1:0];

  // Second half always targets the following aligned word
  assign addr_next_word = {addr[DATA_W-1:2], 2'b00} + DATA_W'(4);

  assign split = is_split(ex_req_i.size, offset);

  // Final phase is the only phase of an unsplit access
  assign last = (phase_q == PHASE_SECOND) || !split;

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_req_i.size)
      SIZE_BYTE: be_base = 4'b0001;
      SIZE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b1111;
    endcase
  end

  // Mask shifted over two words
  // upper nibble holds the bytes that spill into the next word
  assign be_wide = {{BE_W{1'b0}}, be_base} << offset;
  assign be      = (phase_q == PHASE_SECOND) ? be_wide[2*BE_W-1:BE_W] : be_wide[BE_W-1:0];

  // Rotate store data left by whole bytes
  // both halves of a split store carry the same rotated word
  assign wdata_dbl = {ex_req_i.wdata, ex_req_i.wdata} << (8 * offset);
  assign wdata_rot = wdata_dbl[2*DATA_W-1:DATA_W];

  ////////////////////////////////////////////////////////////////////////////
  // Bus request and handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Hold off while the queue cannot take another record
  assign obi_req_o = ex_valid_i && !full_i;
  assign grant     = obi_req_o && obi_gnt_i;

  always_comb begin
    obi_o.addr  = (phase_q == PHASE_SECOND) ? addr_next_word : addr;
    obi_o.we    = ex_req_i.we;
    obi_o.be    = be;
    obi_o.wdata = wdata_rot;
  end

  // EX moves on only once its final address phase is granted
  assign ex_ready_o = !ex_valid_i || (grant && last);

  // One record per granted transaction
  assign push_o = grant;

  always_comb begin
    push_ctrl_o.size   = ex_req_i.size;
    push_ctrl_o.sext   = ex_req_i.sext;
    push_ctrl_o.we     = ex_req_i.we;
    push_ctrl_o.offset = offset;
    push_ctrl_o.last   = last;
  end

  // Phase tracking
  // An idle EX forces the next operation to start in the first phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PHASE_FIRST;
    end else if (!ex_valid_i) begin
      phase_q <= PHASE_FIRST;
    end else if (grant) begin
      phase_q <= last ? PHASE_FIRST : PHASE_SECOND;
    end
  end

endmodule

// File: lsu_pending_queue.sv
////////////////////////////////////////////////////////////////////////////
// LSU pending queue
// In-order FIFO of response-control records, one per granted bus
// transaction, popped by each response; flags a response with none due
////////////////////////////////////////////////////////////////////////////

module lsu_pending_queue #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  lsu_pkg::resp_ctrl_t push_ctrl_i,
  input  logic                pop_i,
  output lsu_pkg::resp_ctrl_t head_ctrl_o,
  output logic                full_o,
  output logic                empty_o,
  output logic                protocol_err_o
);

  import lsu_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  resp_ctrl_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // A response with nothing outstanding is dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign protocol_err_o = pop_i && empty_o;

  assign head_ctrl_o = mem[rd_ptr_q];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_ctrl_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: lsu_resp_align.sv
////////////////////////////////////////////////////////////////////////////
// LSU response alignment
// Realigns returning read data, merges the two halves of a split load
// and sign- or zero-extends the result for the WB stage
////////////////////////////////////////////////////////////////////////////

module lsu_resp_align (
  input  logic                clk,
  input  logic                rst_n,

  // Bus response with the record of its transaction
  input  logic                rvalid_i,
  input  lsu_pkg::obi_resp_t  resp_i,
  input  lsu_pkg::resp_ctrl_t ctrl_i,

  // WB stage
  output logic                wb_valid_o,
  output logic                wb_last_o,
  output logic [31:0]         wb_rdata_o,
  output logic                wb_err_o
);

  import lsu_pkg::*;

  logic [DATA_W-1:0]   rdata_q;
  logic                ctrl_split;
  logic                store_low;
  logic [2*DATA_W-1:0] rdata_full;
  logic [2*DATA_W-1:0] rdata_shift;
  logic [DATA_W-1:0]   rdata_ext;

  ////////////////////////////////////////////////////////////////////////////
  // First-half capture
  ////////////////////////////////////////////////////////////////////////////

  // Only loads need the low word kept
  assign store_low = rvalid_i && !ctrl_i.we && !ctrl_i.last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (store_low) begin
      rdata_q <= resp_i.rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realignment and extension
  ////////////////////////////////////////////////////////////////////////////

  // Same rule the request side used to split the access
  assign ctrl_split = is_split(ctrl_i.size, ctrl_i.offset);

  // Split access
  // stored word holds the low bytes, this response the high ones
  // Unsplit access doubles the word so the shift wraps like a rotate
  assign rdata_full = ctrl_split ? {resp_i.rdata, rdata_q} :
                                   {resp_i.rdata, resp_i.rdata};

  // Addressed byte lands in bit 0
  assign rdata_shift = rdata_full >> (8 * ctrl_i.offset);

  always_comb begin
    case (ctrl_i.size)
      SIZE_BYTE: begin
        rdata_ext = {{(DATA_W-8){ctrl_i.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      end
      SIZE_HALF: begin
        rdata_ext = {{(DATA_W-16){ctrl_i.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      end
      default: begin
        rdata_ext = rdata_shift[DATA_W-1:0];
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // WB outputs
  ////////////////////////////////////////////////////////////////////////////

  // Every response reaches WB, both halves of a split included
  assign wb_valid_o = rvalid_i;
  assign wb_last_o  = ctrl_i.last;

  // Result only meaningful on the last response of a load
  assign wb_rdata_o = rdata_ext;

  // Bus error reported per response
  assign wb_err_o = resp_i.err;

endmodule

// File: lsu_top.sv
////////////////////////////////////////////////////////////////////////////
// Load/store unit top level
// Request generation in EX, a queue of outstanding transactions and
// read-data alignment in WB, connected to the data bus
////////////////////////////////////////////////////////////////////////////

module lsu_top #(
  parameter int unsigned DEPTH = lsu_pkg::DEPTH_DEFAULT
) (
  input  logic               clk,
  input  logic               rst_n,

  // EX stage
  input  logic               ex_valid_i,
  input  lsu_pkg::lsu_req_t  ex_req_i,
  output logic               ex_ready_o,

  // WB stage
  output logic               wb_valid_o,
  output logic               wb_last_o,
  output logic [31:0]        wb_rdata_o,
  output logic               wb_err_o,

  // Data bus
  output logic               obi_req_o,
  input  logic               obi_gnt_i,
  output lsu_pkg::obi_req_t  obi_o,
  input  logic               obi_rvalid_i,
  input  lsu_pkg::obi_resp_t obi_resp_i,

  // Status
  output logic               busy_o,
  output logic               protocol_err_o
);

  import lsu_pkg::*;

  logic       full;
  logic       empty;
  logic       push;
  resp_ctrl_t push_ctrl;
  resp_ctrl_t head_ctrl;

  ////////////////////////////////////////////////////////////////////////////
  // EX stage request side
  ////////////////////////////////////////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_valid_i  (ex_valid_i),
    .ex_req_i    (ex_req_i),
    .ex_ready_o  (ex_ready_o),
    .full_i      (full),
    .obi_req_o   (obi_req_o),
    .obi_gnt_i   (obi_gnt_i),
    .obi_o       (obi_o),
    .push_o      (push),
    .push_ctrl_o (push_ctrl)
  );

  // Each response retires the oldest outstanding record
  lsu_pending_queue #(
    .DEPTH (DEPTH)
  ) u_pending_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_i         (push),
    .push_ctrl_i    (push_ctrl),
    .pop_i          (obi_rvalid_i),
    .head_ctrl_o    (head_ctrl),
    .full_o         (full),
    .empty_o        (empty),
    .protocol_err_o (protocol_err_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // WB stage response side
  ////////////////////////////////////////////////////////////////////////////

  lsu_resp_align u_resp_align (
    .clk        (clk),
    .rst_n      (rst_n),
    .rvalid_i   (obi_rvalid_i),
    .resp_i     (obi_resp_i),
    .ctrl_i     (head_ctrl),
    .wb_valid_o (wb_valid_o),
    .wb_last_o  (wb_last_o),
    .wb_rdata_o (wb_rdata_o),
    .wb_err_o   (wb_err_o)
  );

  // Busy with a request on the bus or any response still due
  assign busy_o = !empty || obi_req_o;

endmodule

// File: lsu_properties.sv
////////////////////////////////////////////////////////////////////////////
// Data bus protocol checks
// Concurrent assertions bound into the LSU top level
////////////////////////////////////////////////////////////////////////////

module lsu_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              obi_req_i,
  input logic              obi_gnt_i,
  input lsu_pkg::obi_req_t obi_i,
  input logic              protocol_err_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Address phase held unchanged until granted
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_i && !obi_gnt_i |=> obi_req_i && $stable(obi_i))
    else $error("obi_o changed or obi_req_o dropped before the grant");

  // Every request touches at least one byte
  a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_i |-> (obi_i.be != '0))
    else $error("obi_o.be is zero while obi_req_o is high");

  // The bus never answers more than was asked
  a_no_protocol_err: assert property (@(posedge clk) disable iff (!rst_n)
    !protocol_err_i)
    else $error("protocol_err_o raised by an unexpected response");

endmodule

bind lsu_top lsu_properties u_lsu_properties (
  .clk            (clk),
  .rst_n          (rst_n),
  .obi_req_i      (obi_req_o),
  .obi_gnt_i      (obi_gnt_i),
  .obi_i          (obi_o),
  .protocol_err_i (protocol_err_o)
);

// File: tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock and an active-low reset held over the first cycles
////////////////////////////////////////////////////////////////////////////

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 20,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the rising edge the DUT uses
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb_lsu.sv
////////////////////////////////////////////////////////////////////////////
// Load/store unit testbench
// Directed and random loads and stores against a 256-byte bus memory
// with random grant and response delays, checked against a byte-level
// reference model
////////////////////////////////////////////////////////////////////////////

module tb_lsu;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  localparam int unsigned DEPTH = 2;

  // Expected WB result for one bus response
  typedef struct packed {
    logic        last;
    logic        is_load;
    logic        err;
    logic [31:0] rdata;
  } exp_rsp_t;

  // Response waiting in the bus model until its due cycle
  typedef struct packed {
    logic [31:0] due;
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  logic       clk;
  logic       rst_n;
  logic       ex_valid_i;
  lsu_req_t   ex_req_i;
  logic       ex_ready_o;
  logic       wb_valid_o;
  logic       wb_last_o;
  logic [31:0] wb_rdata_o;
  logic       wb_err_o;
  logic       obi_req_o;
  logic       obi_gnt_i;
  obi_req_t   obi_o;
  logic       obi_rvalid_i;
  obi_resp_t  obi_resp_i;
  logic       busy_o;
  logic       protocol_err_o;

  logic [7:0]  bus_mem [256];
  logic [7:0]  ref_mem [256];
  obi_req_t    exp_obi_q [$];
  exp_rsp_t    exp_rsp_q [$];
  bus_rsp_t    bus_rsp_q [$];
  int unsigned seed_val;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top #(
    .DEPTH (DEPTH)
  ) i_lsu_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_i),
    .ex_req_i       (ex_req_i),
    .ex_ready_o     (ex_ready_o),
    .wb_valid_o     (wb_valid_o),
    .wb_last_o      (wb_last_o),
    .wb_rdata_o     (wb_rdata_o),
    .wb_err_o       (wb_err_o),
    .obi_req_o      (obi_req_o),
    .obi_gnt_i      (obi_gnt_i),
    .obi_o          (obi_o),
    .obi_rvalid_i   (obi_rvalid_i),
    .obi_resp_i     (obi_resp_i),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_obi(input string name, input obi_req_t act, input obi_req_t exp);
    if (act !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      report_failure("Bus request mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      report_failure("Read data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, act, exp);
      report_failure("Flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int size_bytes(input lsu_size_e size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  // Error window is the top 16 bytes of the memory
  function automatic logic in_window(input int addr);
    return (addr >= 240) && (addr < 256);
  endfunction

  function automatic logic [31:0] rotate_left(input logic [31:0] w, input int off);
    return (w << (8 * off)) | (w >> (32 - 8 * off));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus model
  ////////////////////////////////////////////////////////////////////////////

  // Samples on the rising edge, drives grant and response on the falling edge
  task automatic bus_model();
    logic [31:0] cyc;
    logic [31:0] last_due;
    int unsigned gnt_wait;
    int unsigned outst;
    logic        hold_valid;
    obi_req_t    hold_obi;
    obi_req_t    req;
    logic [7:0]  base;
    bus_rsp_t    rsp;
    exp_rsp_t    exp;
    int          i;
    cyc        = '0;
    last_due   = '0;
    gnt_wait   = $urandom_range(0, 3);
    outst      = 0;
    hold_valid = 1'b0;
    hold_obi   = '0;
    forever begin
      @(posedge clk);
      cyc++;
      check_flag("protocol_err_o", protocol_err_o, 1'b0);
      // Ungranted request must come back unchanged
      if (hold_valid) begin
        check_flag("obi_req_o", obi_req_o, 1'b1);
        check_obi("obi_o", obi_o, hold_obi);
      end
      hold_valid = obi_req_o && !obi_gnt_i;
      hold_obi   = obi_o;
      if (obi_req_o && obi_gnt_i) begin
        req = obi_o;
        if (exp_obi_q.size() == 0) begin
          report_failure("Bus request granted while none was expected");
        end else begin
          check_obi("obi_o", req, exp_obi_q.pop_front());
        end
        base      = {req.addr[7:2], 2'b00};
        rsp.err   = (req.addr[31:4] == 28'h000000f);
        rsp.rdata = {bus_mem[base + 3], bus_mem[base + 2], bus_mem[base + 1], bus_mem[base]};
        // Stores into the error window are dropped
        if (req.we && !rsp.err) begin
          for (i = 0; i < 4; i++) begin
            if (req.be[i]) begin
              bus_mem[base + i] = req.wdata[8*i +: 8];
            end
          end
        end
        rsp.due = cyc + $urandom_range(1, 3);
        if (rsp.due <= last_due) begin
          rsp.due = last_due + 1;
        end
        last_due = rsp.due;
        bus_rsp_q.push_back(rsp);
        outst++;
        gnt_wait = $urandom_range(0, 3);
      end else if (obi_req_o && (gnt_wait > 0)) begin
        gnt_wait--;
      end
      if (obi_rvalid_i) begin
        outst--;
        if (exp_rsp_q.size() == 0) begin
          report_failure("Bus response arrived while none was expected");
        end else begin
          exp = exp_rsp_q.pop_front();
          check_flag("wb_valid_o", wb_valid_o, 1'b1);
          check_flag("wb_last_o", wb_last_o, exp.last);
          check_flag("wb_err_o", wb_err_o, exp.err);
          if (exp.is_load && exp.last) begin
            check_word("wb_rdata_o", wb_rdata_o, exp.rdata);
          end
        end
      end else begin
        check_flag("wb_valid_o", wb_valid_o, 1'b0);
      end
      if (outst > DEPTH) begin
        report_failure("More bus transactions outstanding than the queue depth allows");
      end
      @(negedge clk);
      obi_gnt_i = (gnt_wait == 0);
      if ((bus_rsp_q.size() > 0) && (bus_rsp_q[0].due == cyc + 1)) begin
        rsp          = bus_rsp_q.pop_front();
        obi_rvalid_i = 1'b1;
        obi_resp_i   = '{rdata: rsp.rdata, err: rsp.err};
      end else begin
        obi_rvalid_i = 1'b0;
        obi_resp_i   = '0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // EX-stage stimulus
  ////////////////////////////////////////////////////////////////////////////

  // One load or store with its expected requests and results taken from ref_mem
  task automatic issue_op(input logic we, input lsu_size_e size, input logic sext,
                          input logic [7:0] addr, input logic [31:0] wdata);
    lsu_req_t req;
    obi_req_t exp_req;
    exp_rsp_t exp_rsp;
    int       nbytes;
    int       off;
    int       addr_hi;
    int       i;
    int       cnt;
    logic [3:0]  be_lo;
    logic [3:0]  be_hi;
    logic [31:0] val;
    logic        split;
    logic        done;
    nbytes  = size_bytes(size);
    off     = addr[1:0];
    split   = (off + nbytes) > 4;
    addr_hi = (addr & 8'hfc) + 4;
    be_lo   = '0;
    be_hi   = '0;
    for (i = 0; i < nbytes; i++) begin
      if (off + i < 4) begin
        be_lo[off + i] = 1'b1;
      end else begin
        be_hi[off + i - 4] = 1'b1;
      end
    end
    // Little-endian assembly followed by extension to the access size
    val = '0;
    for (i = nbytes - 1; i >= 0; i--) begin
      val = (val << 8) | ref_mem[8'(addr + i)];
    end
    if (nbytes == 1) begin
      val = sext ? {{24{val[7]}}, val[7:0]} : {24'h0, val[7:0]};
    end else if (nbytes == 2) begin
      val = sext ? {{16{val[15]}}, val[15:0]} : {16'h0, val[15:0]};
    end
    if (we) begin
      for (i = 0; i < nbytes; i++) begin
        if (!in_window(addr + i)) begin
          ref_mem[8'(addr + i)] = wdata[8*i +: 8];
        end
      end
    end
    req.operand_a = $urandom;
    req.operand_b = {24'h0, addr} - req.operand_a;
    req.wdata     = wdata;
    req.size      = size;
    req.sext      = sext;
    req.we        = we;
    @(negedge clk);
    exp_req = '{addr: {24'h0, addr}, we: we, be: be_lo, wdata: rotate_left(wdata, off)};
    exp_obi_q.push_back(exp_req);
    if (split) begin
      exp_req.addr = 32'(addr_hi);
      exp_req.be   = be_hi;
      exp_obi_q.push_back(exp_req);
      exp_rsp = '{last: 1'b0, is_load: !we, err: in_window(addr), rdata: '0};
      exp_rsp_q.push_back(exp_rsp);
      exp_rsp = '{last: 1'b1, is_load: !we, err: in_window(addr_hi), rdata: val};
      exp_rsp_q.push_back(exp_rsp);
    end else begin
      exp_rsp = '{last: 1'b1, is_load: !we, err: in_window(addr), rdata: val};
      exp_rsp_q.push_back(exp_rsp);
    end
    ex_valid_i = 1'b1;
    ex_req_i   = req;
    done = 1'b0;
    cnt  = 0;
    while (!done && (cnt < 50)) begin
      @(posedge clk);
      done = ex_ready_o;
      cnt++;
    end
    if (!done) begin
      report_failure("EX handshake did not complete within 50 cycles");
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    ex_valid_i = 1'b0;
    ex_req_i   = '0;
  endtask

  initial begin
    int   a;
    int   n;
    int   cnt;
    logic done;
    ex_valid_i   = 1'b0;
    ex_req_i     = '0;
    obi_gnt_i    = 1'b0;
    obi_rvalid_i = 1'b0;
    obi_resp_i   = '0;
    seed_val     = $urandom(32'hdac5);
    // Odd multiplier makes every byte depend on its whole address
    for (a = 0; a < 256; a++) begin
      bus_mem[a] = 8'(a * 29) ^ 8'hc3;
      ref_mem[a] = 8'(a * 29) ^ 8'hc3;
    end
    done = 1'b0;
    cnt  = 0;
    while (!done && (cnt < 50)) begin
      @(posedge clk);
      done = rst_n;
      cnt++;
    end
    if (!done) begin
      report_failure("Reset was not released within 50 cycles");
    end
    check_flag("obi_req_o", obi_req_o, 1'b0);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("protocol_err_o", protocol_err_o, 1'b0);
    fork
      bus_model();
    join_none

    // Aligned stores
    issue_op(1'b1, SIZE_BYTE, 1'b0, 8'h10, 32'h0000_00a5);
    issue_op(1'b1, SIZE_BYTE, 1'b0, 8'h13, 32'h0000_0081);
    issue_op(1'b1, SIZE_HALF, 1'b0, 8'h20, 32'h0000_beef);
    issue_op(1'b1, SIZE_HALF, 1'b0, 8'h22, 32'h0000_8123);
    issue_op(1'b1, SIZE_WORD, 1'b0, 8'h30, 32'hcafe_f00d);
    idle_cycle();
    // Aligned and non-split misaligned loads
    issue_op(1'b0, SIZE_BYTE, 1'b0, 8'h13, '0);
    issue_op(1'b0, SIZE_BYTE, 1'b1, 8'h13, '0);
    issue_op(1'b0, SIZE_HALF, 1'b1, 8'h22, '0);
    issue_op(1'b0, SIZE_HALF, 1'b0, 8'h21, '0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 8'h30, '0);
    issue_op(1'b0, SIZE_BYTE, 1'b1, 8'h0a, '0);
    idle_cycle();
    // Split word and halfword accesses
    issue_op(1'b1, SIZE_WORD, 1'b0, 8'h41, 32'h1234_5678);
    issue_op(1'b0, SIZE_WORD, 1'b0, 8'h41, '0);
    issue_op(1'b1, SIZE_HALF, 1'b0, 8'h53, 32'h0000_9abc);
    issue_op(1'b0, SIZE_HALF, 1'b1, 8'h53, '0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 8'h46, '0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 8'h67, '0);
    idle_cycle();
    // Back-to-back random traffic
    for (n = 0; n < 150; n++) begin
      issue_op(1'($urandom_range(0, 1)), lsu_size_e'($urandom_range(0, 2)),
               1'($urandom_range(0, 1)), 8'($urandom_range(0, 255)), $urandom);
      if ($urandom_range(0, 3) == 0) begin
        idle_cycle();
      end
    end
    // Error window accesses including splits that enter or leave it
    issue_op(1'b1, SIZE_WORD, 1'b0, 8'hf4, 32'hdead_beef);
    issue_op(1'b0, SIZE_WORD, 1'b0, 8'hf4, '0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 8'hee, '0);
    issue_op(1'b1, SIZE_BYTE, 1'b0, 8'hff, 32'h0000_0077);
    issue_op(1'b0, SIZE_WORD, 1'b1, 8'hfd, '0);
    issue_op(1'b0, SIZE_HALF, 1'b1, 8'hef, '0);
    idle_cycle();

    // Drain all outstanding responses
    done = 1'b0;
    cnt  = 0;
    while (!done && (cnt < 50)) begin
      @(negedge clk);
      done = (exp_rsp_q.size() == 0);
      cnt++;
    end
    if (!done) begin
      report_failure("Outstanding responses did not drain within 50 cycles");
    end
    check_flag("busy_o", busy_o, 1'b0);
    if ((exp_obi_q.size() == 0) && (exp_rsp_q.size() == 0)) begin
      $display("Done: no errors");
      $finish;
    end else begin
      report_failure("Expected bus requests or responses never occurred");
    end
  end

endmodule

// File: verilog.f
lsu_pkg.sv
lsu_req_gen.sv
lsu_pending_queue.sv
lsu_resp_align.sv
lsu_top.sv
lsu_properties.sv
tb_clk_gen.sv
tb_lsu.sv
